// File: Makefile
SRCS := $(shell cat chroma_mode_top.f)
BIN  := obj_dir/Vtb_chroma_mode

.PHONY: all run clean

all: run

$(BIN): chroma_mode_top.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_chroma_mode \
		-f chroma_mode_top.f -Mdir obj_dir

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: chroma_mode_top.f
logic/chroma_pkg.sv
logic/chroma_pred.sv
logic/chroma_recon.sv
logic/uv_cost_eval.sv
logic/uv_mode_select.sv
logic/chroma_mode_top.sv
tests/chroma_mode_assertions.sv
tests/tb_chroma_mode.sv

// File: logic/chroma_mode_top.sv
// Chroma intra mode decision top level joining predictor, recon, cost and selector
`timescale 1ns/1ps

module chroma_mode_top
    import chroma_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic [9:0]   mb_x,
    input  logic [9:0]   mb_y,
    input  logic [31:0]  lambda_uv,
    input  logic [2:0]   q_shift,
    input  uv_block_t    src,
    input  uv_edges_t    edges,
    output uv_mode_e     best_mode,
    output logic [63:0]  best_score,
    output uv_block_t    recon,
    output uv_levels_t   levels,
    output logic [7:0]   nz,
    output logic         done
);

    // Row count follows the package block type
    localparam int BLOCK_ROWS = UV_ROWS;

    uv_pred_set_t  pred_set;
    uv_block_t     cur_pred;
    logic          rec_start;
    logic          row_valid;
    uv_row_t       row_src;
    uv_row_t       row_rec;
    uv_level_row_t row_lvl;
    uv_block_t     blk_rec;
    uv_levels_t    blk_lvl;
    logic [7:0]    blk_nz;
    logic [31:0]   sse;
    logic [31:0]   rate;
    logic          eval_done;

    chroma_pred u_pred (
        .mb_x     (mb_x),
        .mb_y     (mb_y),
        .edges    (edges),
        .pred_set (pred_set)
    );

    chroma_recon #(.BLOCK_ROWS(BLOCK_ROWS)) u_recon (
        .clk       (clk),
        .rst_n     (rst_n),
        .rec_start (rec_start),
        .q_shift   (q_shift),
        .src       (src),
        .cur_pred  (cur_pred),
        .row_valid (row_valid),
        .row_src   (row_src),
        .row_rec   (row_rec),
        .row_lvl   (row_lvl),
        .blk_rec   (blk_rec),
        .blk_lvl   (blk_lvl),
        .blk_nz    (blk_nz)
    );

    uv_cost_eval #(.BLOCK_ROWS(BLOCK_ROWS)) u_cost (
        .clk       (clk),
        .rst_n     (rst_n),
        .rec_start (rec_start),
        .row_valid (row_valid),
        .row_src   (row_src),
        .row_rec   (row_rec),
        .row_lvl   (row_lvl),
        .sse       (sse),
        .rate      (rate),
        .eval_done (eval_done)
    );

    uv_mode_select u_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .lambda_uv  (lambda_uv),
        .pred_set   (pred_set),
        .sse        (sse),
        .rate       (rate),
        .eval_done  (eval_done),
        .blk_rec    (blk_rec),
        .blk_lvl    (blk_lvl),
        .blk_nz     (blk_nz),
        .rec_start  (rec_start),
        .cur_pred   (cur_pred),
        .best_mode  (best_mode),
        .best_score (best_score),
        .recon      (recon),
        .levels     (levels),
        .nz         (nz),
        .done       (done)
    );

endmodule

// File: logic/chroma_pkg.sv
// Chroma mode decision shared types, mode codes and fixed mode costs
package chroma_pkg;

    localparam int UV_ROWS = 8;

    // Try order is the encoding order
    typedef enum logic [1:0] {
        UV_DC = 2'd0,
        UV_TM = 2'd1,
        UV_VE = 2'd2,
        UV_HE = 2'd3
    } uv_mode_e;

    // Mode header cost, indexed by uv_mode_e
    localparam logic [3:0][15:0] fixed_cost = {16'd642, 16'd439, 16'd984, 16'd302};

    typedef logic [7:0] pixel_t;

    // Bytes 0..7 are U columns, 8..15 are V columns
    typedef pixel_t [15:0] uv_row_t;
    typedef uv_row_t [UV_ROWS-1:0] uv_block_t;

    typedef struct packed {
        pixel_t [7:0] top_u;
        pixel_t [7:0] top_v;
        pixel_t [7:0] left_u;
        pixel_t [7:0] left_v;
        pixel_t       top_left_u;
        pixel_t       top_left_v;
    } uv_edges_t;

    typedef logic signed [8:0] level_t;
    typedef level_t [15:0] uv_level_row_t;
    typedef uv_level_row_t [UV_ROWS-1:0] uv_levels_t;

    typedef uv_block_t [3:0] uv_pred_set_t;

    // Saturate a signed intermediate back to pixel range
    function automatic pixel_t clip_pixel(input logic signed [9:0] v);
        if (v < 0)
            return 8'd0;
        if (v > 10'sd255)
            return 8'd255;
        return v[7:0];
    endfunction

endpackage

// File: logic/chroma_pred.sv
// Chroma predictor builder for DC, TrueMotion, Vertical and Horizontal modes
`timescale 1ns/1ps

module chroma_pred
    import chroma_pkg::*;
(
    input  logic [9:0]   mb_x,
    input  logic [9:0]   mb_y,
    input  uv_edges_t    edges,
    output uv_pred_set_t pred_set
);

    logic   has_top;
    logic   has_left;
    pixel_t dc_u;
    pixel_t dc_v;

    // DC value from whichever edges are present
    function automatic pixel_t dc_value(
        input pixel_t [7:0] top,
        input pixel_t [7:0] left,
        input logic         use_top,
        input logic         use_left
    );
        logic [11:0] sum_top;
        logic [11:0] sum_left;
        logic [11:0] total;
        sum_top  = '0;
        sum_left = '0;
        for (int i = 0; i < 8; i++) begin
            sum_top  = sum_top + 12'(top[i]);
            sum_left = sum_left + 12'(left[i]);
        end
        if (use_top && use_left) begin
            total = sum_top + sum_left + 12'd8;
            return total[11:4];
        end
        if (use_top || use_left) begin
            total = (use_top ? sum_top : sum_left) + 12'd4;
            return total[10:3];
        end
        return 8'd128;
    endfunction

    assign has_top  = (mb_y != '0);
    assign has_left = (mb_x != '0);

    assign dc_u = dc_value(edges.top_u, edges.left_u, has_top, has_left);
    assign dc_v = dc_value(edges.top_v, edges.left_v, has_top, has_left);

    always_comb begin
        for (int r = 0; r < UV_ROWS; r++) begin
            for (int c = 0; c < 8; c++) begin
                pred_set[UV_DC][r][c]     = dc_u;
                pred_set[UV_DC][r][8 + c] = dc_v;
                // Left plus top minus corner
                pred_set[UV_TM][r][c]     = clip_pixel(10'(edges.left_u[r]) +
                    10'(edges.top_u[c]) - 10'(edges.top_left_u));
                pred_set[UV_TM][r][8 + c] = clip_pixel(10'(edges.left_v[r]) +
                    10'(edges.top_v[c]) - 10'(edges.top_left_v));
                pred_set[UV_VE][r][c]     = edges.top_u[c];
                pred_set[UV_VE][r][8 + c] = edges.top_v[c];
                pred_set[UV_HE][r][c]     = edges.left_u[r];
                pred_set[UV_HE][r][8 + c] = edges.left_v[r];
            end
        end
    end

endmodule

// File: logic/chroma_recon.sv
// Row-serial quantizer and reconstructor holding the finished chroma block
`timescale 1ns/1ps

module chroma_recon
    import chroma_pkg::*;
#(
    parameter int BLOCK_ROWS = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          rec_start,
    input  logic [2:0]    q_shift,
    input  uv_block_t     src,
    input  uv_block_t     cur_pred,
    output logic          row_valid,
    output uv_row_t       row_src,
    output uv_row_t       row_rec,
    output uv_level_row_t row_lvl,
    output uv_block_t     blk_rec,
    output uv_levels_t    blk_lvl,
    output logic [7:0]    blk_nz
);

    localparam int CW = $clog2(BLOCK_ROWS) + 1;

    logic [CW-1:0] row_cnt;
    logic [CW-2:0] row_idx;
    logic          row_step;
    uv_row_t       src_row;
    uv_row_t       pred_row;
    uv_row_t       rec_next;
    uv_level_row_t lvl_next;
    logic [3:0]    half_nz;
    logic [7:0]    row_nz;

    assign row_step = rec_start || (row_valid && row_cnt != CW'(BLOCK_ROWS));
    assign row_idx  = rec_start ? '0 : row_cnt[CW-2:0];
    assign src_row  = src[row_idx];
    assign pred_row = cur_pred[row_idx];

    // ----------------------------------------
    // Per-pixel quantize and reconstruct
    // ----------------------------------------
    always_comb begin
        logic signed [9:0] base;
        logic signed [9:0] resid;
        logic signed [9:0] dq_s;
        logic              neg;
        logic [7:0]        mag;
        logic [7:0]        q;
        level_t            q_lvl;
        half_nz = '0;
        for (int i = 0; i < 16; i++) begin
            base  = $signed({2'b00, pred_row[i]});
            resid = $signed({2'b00, src_row[i]}) - base;
            neg   = resid[9];
            mag   = neg ? 8'(-resid) : resid[7:0];
            q     = mag >> q_shift;
            q_lvl = $signed({1'b0, q});
            lvl_next[i] = neg ? -q_lvl : q_lvl;
            dq_s  = $signed({2'b00, 8'(q << q_shift)});
            rec_next[i] = clip_pixel(neg ? base - dq_s : base + dq_s);
            half_nz[i / 4] = half_nz[i / 4] | (q != '0);
        end
    end

    // U in bits 0..3, V in bits 4..7, raster order per plane
    assign row_nz = (row_idx >= (BLOCK_ROWS / 2)) ?
                    {half_nz[3:2], 2'b00, half_nz[1:0], 2'b00} :
                    {2'b00, half_nz[3:2], 2'b00, half_nz[1:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_valid <= 1'b0;
            row_cnt   <= '0;
        end else if (rec_start) begin
            row_valid <= 1'b1;
            row_cnt   <= CW'(1);
        end else if (row_step) begin
            row_cnt   <= row_cnt + 1'b1;
        end else begin
            row_valid <= 1'b0;
            row_cnt   <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (row_step) begin
            row_src          <= src_row;
            row_rec          <= rec_next;
            row_lvl          <= lvl_next;
            blk_rec[row_idx] <= rec_next;
            blk_lvl[row_idx] <= lvl_next;
            blk_nz           <= rec_start ? row_nz : (blk_nz | row_nz);
        end
    end

endmodule

// File: logic/uv_cost_eval.sv
// Distortion and rate accumulator over the reconstructed row stream
`timescale 1ns/1ps

module uv_cost_eval
    import chroma_pkg::*;
#(
    parameter int BLOCK_ROWS = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          rec_start,
    input  logic          row_valid,
    input  uv_row_t       row_src,
    input  uv_row_t       row_rec,
    input  uv_level_row_t row_lvl,
    output logic [31:0]   sse,
    output logic [31:0]   rate,
    output logic          eval_done
);

    localparam int CW = $clog2(BLOCK_ROWS);

    logic [CW-1:0] row_cnt;
    logic [31:0]   row_sse;
    logic [31:0]   row_rate;

    always_comb begin
        logic [7:0] diff;
        logic [8:0] lvl_abs;
        row_sse  = '0;
        row_rate = '0;
        for (int i = 0; i < 16; i++) begin
            diff     = (row_src[i] > row_rec[i]) ? row_src[i] - row_rec[i]
                                                 : row_rec[i] - row_src[i];
            lvl_abs  = row_lvl[i][8] ? 9'(-row_lvl[i]) : row_lvl[i];
            row_sse  = row_sse + 32'(diff) * 32'(diff);
            row_rate = row_rate + 32'(lvl_abs);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sse       <= '0;
            rate      <= '0;
            row_cnt   <= '0;
            eval_done <= 1'b0;
        end else if (rec_start) begin
            sse       <= '0;
            rate      <= '0;
            row_cnt   <= '0;
            eval_done <= 1'b0;
        end else begin
            // Fires the cycle after the last row
            eval_done <= row_valid && (row_cnt == CW'(BLOCK_ROWS - 1));
            if (row_valid) begin
                sse     <= sse + row_sse;
                rate    <= rate + row_rate;
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/uv_mode_select.sv
// Mode sequencer that scores the four chroma modes and keeps the best one
`timescale 1ns/1ps

module uv_mode_select
    import chroma_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  logic [31:0]  lambda_uv,
    input  uv_pred_set_t pred_set,
    input  logic [31:0]  sse,
    input  logic [31:0]  rate,
    input  logic         eval_done,
    input  uv_block_t    blk_rec,
    input  uv_levels_t   blk_lvl,
    input  logic [7:0]   blk_nz,
    output logic         rec_start,
    output uv_block_t    cur_pred,
    output uv_mode_e     best_mode,
    output logic [63:0]  best_score,
    output uv_block_t    recon,
    output uv_levels_t   levels,
    output logic [7:0]   nz,
    output logic         done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LAUNCH,
        S_WAIT,
        S_SCORE,
        S_COMPARE,
        S_FINISH
    } state_e;

    state_e      state;
    state_e      state_nxt;
    uv_mode_e    cur_mode;
    logic [63:0] score_reg;
    logic [63:0] score_nxt;
    logic        take_best;

    assign rec_start = (state == S_LAUNCH);
    assign done      = (state == S_FINISH);
    assign cur_pred  = pred_set[cur_mode];

    // (rate * 1024 + header cost) * lambda + 256 * distortion
    assign score_nxt = (((64'(rate) << 10) + 64'(fixed_cost[cur_mode])) * 64'(lambda_uv))
                       + (64'(sse) << 8);

    // First mode always lands, later ones only on a strictly lower score
    assign take_best = (cur_mode == UV_DC) || (score_reg < best_score);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:    if (start) state_nxt = S_LAUNCH;
            S_LAUNCH:  state_nxt = S_WAIT;
            S_WAIT:    if (eval_done) state_nxt = S_SCORE;
            S_SCORE:   state_nxt = S_COMPARE;
            S_COMPARE: state_nxt = (cur_mode == UV_HE) ? S_FINISH : S_LAUNCH;
            S_FINISH:  state_nxt = S_IDLE;
            default:   state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            cur_mode   <= UV_DC;
            score_reg  <= '0;
            best_mode  <= UV_DC;
            best_score <= '0;
            recon      <= '0;
            levels     <= '0;
            nz         <= '0;
        end else begin
            state <= state_nxt;
            case (state)
                S_IDLE:  cur_mode  <= UV_DC;
                S_SCORE: score_reg <= score_nxt;
                S_COMPARE: begin
                    if (take_best) begin
                        best_mode  <= cur_mode;
                        best_score <= score_reg;
                        recon      <= blk_rec;
                        levels     <= blk_lvl;
                        nz         <= blk_nz;
                    end
                    cur_mode <= uv_mode_e'(2'(cur_mode + 2'd1));
                end
                default: ;
            endcase
        end
    end

endmodule

// File: tests/chroma_mode_assertions.sv
// Protocol checks for the chroma mode decision, bound into the top level
`timescale 1ns/1ps

module chroma_mode_assertions (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic done,
    input logic rec_start,
    input logic eval_done,
    input logic row_valid
);

    localparam int DONE_DELAY = 49;
    localparam int ROW_COUNT  = 8;

    int         fail_count = 0;
    logic       busy;
    logic [6:0] busy_cycles;
    logic       eval_pending;
    logic [3:0] row_run;

    // ----------------------------------------
    // Shadow state of the sequencer
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            busy_cycles  <= '0;
            eval_pending <= 1'b0;
            row_run      <= '0;
        end else begin
            if (start && !busy) begin
                busy        <= 1'b1;
                busy_cycles <= 7'd1;
            end else if (busy) begin
                busy        <= !done;
                busy_cycles <= busy_cycles + 7'd1;
            end
            if (rec_start)
                eval_pending <= 1'b1;
            else if (eval_done)
                eval_pending <= 1'b0;
            row_run <= row_valid ? row_run + 4'd1 : 4'd0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (busy && busy_cycles == 7'(DONE_DELAY)))
        else begin
            $error("done arrived without a start 49 cycles before");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (busy && busy_cycles == 7'(DONE_DELAY)) |-> done)
        else begin
            $error("done missing 49 cycles after start");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) rec_start |-> !eval_pending)
        else begin
            $error("rec_start repeated before eval_done");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) row_valid |-> row_run < 4'(ROW_COUNT))
        else begin
            $error("row_valid held longer than one block");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (!row_valid && $past(row_valid)) |-> row_run == 4'(ROW_COUNT))
        else begin
            $error("row_valid burst shorter than one block");
            fail_count++;
        end

endmodule

bind chroma_mode_top chroma_mode_assertions u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .done      (done),
    .rec_start (rec_start),
    .eval_done (eval_done),
    .row_valid (row_valid)
);

// File: tests/tb_chroma_mode.sv
// Testbench for the chroma mode decision with a reference model of all four modes
`timescale 1ns/1ps

module tb_chroma_mode
    import chroma_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int BLOCK_ROWS   = 8;
    localparam int NUM_BLOCKS   = 12;
    // Twelve blocks of about 50 cycles each plus reset, with margin
    localparam int MAX_CYCLES   = 1000;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [9:0]  mb_x;
    logic [9:0]  mb_y;
    logic [31:0] lambda_uv;
    logic [2:0]  q_shift;
    uv_block_t   src;
    uv_edges_t   edges;
    uv_mode_e    best_mode;
    logic [63:0] best_score;
    uv_block_t   recon;
    uv_levels_t  levels;
    logic [7:0]  nz;
    logic        done;

    // Next block, driven together with start
    uv_block_t   nx_src;
    uv_edges_t   nx_edges;
    logic [9:0]  nx_mb_x;
    logic [9:0]  nx_mb_y;
    logic [31:0] nx_lambda;
    logic [2:0]  nx_q;
    logic [31:0] rng;
    int          errors;
    int          cycles;
    int unsigned mode_cost [4] = '{302, 984, 439, 642};

    chroma_mode_top i_chroma_mode_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .mb_x       (mb_x),
        .mb_y       (mb_y),
        .lambda_uv  (lambda_uv),
        .q_shift    (q_shift),
        .src        (src),
        .edges      (edges),
        .best_mode  (best_mode),
        .best_score (best_score),
        .recon      (recon),
        .levels     (levels),
        .nz         (nz),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x   = rng;
        x   = x ^ (x << 13);
        x   = x ^ (x >> 17);
        x   = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic int saturate_pixel(int v);
        return (v < 0) ? 0 : ((v > 255) ? 255 : v);
    endfunction

    function automatic int top_px(int plane, int i);
        return plane ? int'(nx_edges.top_v[i]) : int'(nx_edges.top_u[i]);
    endfunction

    function automatic int left_px(int plane, int i);
        return plane ? int'(nx_edges.left_v[i]) : int'(nx_edges.left_u[i]);
    endfunction

    // DC uses only the edges that exist at this position
    function automatic int dc_px(int plane);
        int sum_top;
        int sum_left;
        logic has_top;
        logic has_left;
        sum_top  = 0;
        sum_left = 0;
        has_top  = (nx_mb_y != 0);
        has_left = (nx_mb_x != 0);
        for (int i = 0; i < 8; i++) begin
            sum_top  += top_px(plane, i);
            sum_left += left_px(plane, i);
        end
        if (has_top && has_left)
            return (sum_top + sum_left + 8) >> 4;
        if (has_top)
            return (sum_top + 4) >> 3;
        if (has_left)
            return (sum_left + 4) >> 3;
        return 128;
    endfunction

    function automatic int pred_px(int m, int r, int c);
        int plane;
        int col;
        int corner;
        plane  = c / 8;
        col    = c % 8;
        corner = plane ? int'(nx_edges.top_left_v) : int'(nx_edges.top_left_u);
        case (m)
            0:       return dc_px(plane);
            1:       return saturate_pixel(left_px(plane, r) + top_px(plane, col) - corner);
            2:       return top_px(plane, col);
            default: return left_px(plane, r);
        endcase
    endfunction

    // ----------------------------------------
    // Reference model over the four modes
    // ----------------------------------------
    task automatic build_reference(output uv_mode_e exp_mode, output logic [63:0] exp_score,
                                   output uv_block_t exp_rec, output uv_levels_t exp_lvl,
                                   output logic [7:0] exp_nz);
        longint unsigned score;
        longint unsigned sse;
        longint unsigned rate;
        uv_block_t       rec_b;
        uv_levels_t      lvl_b;
        logic [7:0]      nz_b;
        int              p;
        int              s;
        int              res;
        int              mag;
        int              lvl;
        int              rv;
        exp_score = '0;
        for (int m = 0; m < 4; m++) begin
            sse  = 0;
            rate = 0;
            nz_b = '0;
            for (int r = 0; r < BLOCK_ROWS; r++) begin
                for (int c = 0; c < 16; c++) begin
                    p   = pred_px(m, r, c);
                    s   = nx_src[r][c];
                    res = s - p;
                    mag = ((res < 0) ? -res : res) >> nx_q;
                    lvl = (res < 0) ? -mag : mag;
                    rv  = saturate_pixel(p + lvl * (1 << nx_q));
                    rec_b[r][c] = 8'(rv);
                    lvl_b[r][c] = 9'(lvl);
                    if (lvl != 0)
                        nz_b[(c / 8) * 4 + (r / 4) * 2 + (c % 8) / 4] = 1'b1;
                    sse  += longint'((s - rv) * (s - rv));
                    rate += longint'(mag);
                end
            end
            score = (rate * 1024 + mode_cost[m]) * nx_lambda + 256 * sse;
            // Ties stay with the earlier mode
            if (m == 0 || score < exp_score) begin
                exp_mode  = uv_mode_e'(m);
                exp_score = score;
                exp_rec   = rec_b;
                exp_lvl   = lvl_b;
                exp_nz    = nz_b;
            end
        end
    endtask

    task automatic check_val(input string name, input logic [1151:0] exp_v,
                             input logic [1151:0] act_v);
        assert (exp_v === act_v)
            else begin
                $display("Fail %s: expected %0h, actual %0h", name, exp_v, act_v);
                errors++;
            end
    endtask

    task automatic make_random(input logic [2:0] q, input logic [9:0] x, input logic [9:0] y);
        for (int r = 0; r < BLOCK_ROWS; r++)
            for (int c = 0; c < 16; c++)
                nx_src[r][c] = 8'(next_random());
        for (int i = 0; i < 8; i++) begin
            nx_edges.top_u[i]  = 8'(next_random());
            nx_edges.top_v[i]  = 8'(next_random());
            nx_edges.left_u[i] = 8'(next_random());
            nx_edges.left_v[i] = 8'(next_random());
        end
        nx_edges.top_left_u = 8'(next_random());
        nx_edges.top_left_v = 8'(next_random());
        nx_lambda = (next_random() & 32'hff) + 32'd1;
        nx_q      = q;
        nx_mb_x   = x;
        nx_mb_y   = y;
    endtask

    task automatic fill_src(input logic [7:0] v);
        for (int r = 0; r < BLOCK_ROWS; r++)
            for (int c = 0; c < 16; c++)
                nx_src[r][c] = v;
    endtask

    task automatic fill_edges(input logic [7:0] v);
        for (int i = 0; i < 8; i++) begin
            nx_edges.top_u[i]  = v;
            nx_edges.top_v[i]  = v;
            nx_edges.left_u[i] = v;
            nx_edges.left_v[i] = v;
        end
        nx_edges.top_left_u = v;
        nx_edges.top_left_v = v;
    endtask

    // Drive one block, optionally poke start mid-run, then compare at done
    task automatic run_block(input string tname, input logic poke_busy);
        uv_mode_e    exp_mode;
        logic [63:0] exp_score;
        uv_block_t   exp_rec;
        uv_levels_t  exp_lvl;
        logic [7:0]  exp_nz;
        build_reference(exp_mode, exp_score, exp_rec, exp_lvl, exp_nz);
        @(posedge clk);
        src       <= nx_src;
        edges     <= nx_edges;
        mb_x      <= nx_mb_x;
        mb_y      <= nx_mb_y;
        lambda_uv <= nx_lambda;
        q_shift   <= nx_q;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (poke_busy) begin
            repeat (20) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        do @(negedge clk); while (done !== 1'b1);
        check_val({tname, " best_mode"}, exp_mode, best_mode);
        check_val({tname, " best_score"}, exp_score, best_score);
        check_val({tname, " recon"}, exp_rec, recon);
        check_val({tname, " levels"}, exp_lvl, levels);
        check_val({tname, " nz"}, exp_nz, nz);
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        mb_x      = '0;
        mb_y      = '0;
        lambda_uv = '0;
        q_shift   = '0;
        src       = '0;
        edges     = '0;
        errors    = 0;
        cycles    = 0;
        rng       = 32'h03f996b6;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(negedge clk);
        check_val("reset done", 1'b0, done);
        check_val("reset best_mode", '0, best_mode);
        check_val("reset best_score", '0, best_score);
        check_val("reset recon", '0, recon);
        check_val("reset levels", '0, levels);
        check_val("reset nz", '0, nz);

        // Flat block, every predictor exact
        make_random(3'd7, 10'd1, 10'd1);
        fill_src(8'd90);
        fill_edges(8'd90);
        run_block("flat", 1'b0);
        check_val("flat mode", UV_DC, best_mode);
        check_val("flat nz", '0, nz);

        make_random(3'd0, 10'd2, 10'd3);
        run_block("q_shift_0", 1'b0);
        check_val("q_shift_0 recon_src", nx_src, recon);

        // No edges at all, DC of 128 matches the source
        make_random(3'd3, 10'd0, 10'd0);
        fill_src(8'd128);
        run_block("no_edges", 1'b0);
        check_val("no_edges mode", UV_DC, best_mode);

        make_random(3'd4, 10'd0, 10'd6);
        run_block("top_only", 1'b0);
        make_random(3'd2, 10'd7, 10'd0);
        run_block("left_only", 1'b0);

        for (int i = 0; i < NUM_BLOCKS - 6; i++) begin
            make_random(3'(2 + i % 4), 10'(i + 1), 10'(i + 2));
            run_block($sformatf("random_%0d_q%0d", i, 2 + i % 4), 1'b0);
        end

        make_random(3'd3, 10'd5, 10'd5);
        run_block("busy_start", 1'b1);

        repeat (2) @(negedge clk);
        $display("Value errors: %0d, assertion errors: %0d", errors,
                 i_chroma_mode_top.u_assert.fail_count);
        if (errors == 0 && i_chroma_mode_top.u_assert.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
